//--- program.hex
// one RV32I instruction word per line, hex, loaded from address 0
// alu group at 0x000
123450B7
67808093
FFB00113
00001197
00208233
402082B3
00209333
001123B3
00113433
0020C4B3
00315533
403155B3
0030E633
0020F6B3
00409713
00315793
40215813
FFC12893
00513913
FFF0C993
07016A13
0FF0FA93
// forwarding at 0x058, load result used at distance 1 and 2
06400B13
016B0BB3
017B0C33
018B0CB3
10000D13
019D2023
000D2D83
01BD8E33
01CD8EB3
// stores and loads of every width at 0x07c
001D2223
002D02A3
000D2423
002D1523
001D0423
005D0183
005D4203
007D0283
004D4303
00AD1383
00AD5403
004D1483
006D5503
008D2583
009D0603
006D0683
// counted loop and branches at 0x0bc, the addi x16 words are wrong path
00300713
00000793
00E787B3
FFF70713
FE071CE3
00E78463
00014463
00100813
00015463
00206463
00200813
0020F463
00000463
00300813
// jal, jalr to an odd address and x0 writes at 0x0f4
00C008EF
00700913
00800913
11100993
00498A67
00900913
00A00913
00B00913
03700013
00000AB3
0080006F
00100A93
// ebreak at 0x124, nothing after it may retire
00100073
00100B93
00200B93

//--- verilog.f
cpuPkg.sv
instRom.sv
decoder.sv
regFile.sv
forwardUnit.sv
alu.sv
dataMem.sv
cpu.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_cpu -f verilog.f -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpuPkg::*; ();

	localparam int RESET_CYCLES = 8;
	// under 300 retirements at up to 3 cycles each, plus margin
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 10;
	localparam int NUM_GROUPS = 6;

	logic clk = 1'b0;
	logic rst;
	logic [XLEN-1:0] pc;
	retireT retire;
	logic halted;

	logic [XLEN-1:0] modelRegs [32];
	logic [7:0] modelMem [RAM_DEPTH];
	logic [XLEN-1:0] modelRom [ROM_DEPTH];
	logic [XLEN-1:0] modelPc;
	logic modelHalted;
	int seed;
	int cycles;
	int retired;
	int modelSteps;
	int otherErrs;
	int curGroup;
	int groupChecks [NUM_GROUPS];
	int groupErrs [NUM_GROUPS];
	retireT want;

	cpu i_dut (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.retire(retire),
		.halted(halted)
	);

	always #4 clk = ~clk;

	function automatic logic [RAM_AW-1:0] byteAt(input logic [31:0] addr, input int k);
		logic [31:0] sum;
		sum = addr + 32'(k);
		return sum[RAM_AW-1:0];
	endfunction

	function automatic logic [31:0] loadValue(input logic [2:0] f3, input logic [31:0] addr);
		logic [31:0] w;
		w = {modelMem[byteAt(addr, 3)], modelMem[byteAt(addr, 2)],
			modelMem[byteAt(addr, 1)], modelMem[byteAt(addr, 0)]};
		case (f3)
			3'd0: return {{24{w[7]}}, w[7:0]};
			3'd1: return {{16{w[15]}}, w[15:0]};
			3'd4: return {24'd0, w[7:0]};
			3'd5: return {16'd0, w[15:0]};
			default: return w;
		endcase
	endfunction

	// little endian, low byte at the address itself
	function automatic void storeValue(input logic [2:0] f3, input logic [31:0] addr,
		input logic [31:0] data);
		int n;
		n = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
		for (int k = 0; k < n; k++) begin
			modelMem[byteAt(addr, k)] = data[8*k +: 8];
		end
	endfunction

	function automatic logic [31:0] intResult(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'd3: return (x < y) ? 32'd1 : 32'd0;
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			3'd7: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	// ISA model, runs one instruction and returns what should retire
	function automatic retireT stepModel();
		retireT r;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] nextPc;
		logic [2:0] f3;
		logic alt;
		inst = modelRom[modelPc[ROM_AW+1:2]];
		f3 = inst[14:12];
		a = modelRegs[inst[19:15]];
		b = modelRegs[inst[24:20]];
		immI = {{20{inst[31]}}, inst[31:20]};
		immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		alt = inst[30] && (inst[6:0] == 7'h33 || f3 == 3'd5);
		nextPc = modelPc + 32'd4;
		r = '0;
		r.valid = 1'b1;
		r.pc = modelPc;
		r.rd = inst[11:7];
		case (inst[6:0])
			7'h37: begin
				r.wen = 1'b1;
				r.wdata = {inst[31:12], 12'd0};
			end
			7'h17: begin
				r.wen = 1'b1;
				r.wdata = modelPc + {inst[31:12], 12'd0};
			end
			7'h6f: begin
				r.wen = 1'b1;
				r.wdata = modelPc + 32'd4;
				nextPc = modelPc + immJ;
			end
			7'h67: begin
				r.wen = 1'b1;
				r.wdata = modelPc + 32'd4;
				nextPc = (a + immI) & ~32'd1;
			end
			7'h63: begin
				if (branchTaken(f3, a, b)) nextPc = modelPc + immB;
			end
			7'h03: begin
				r.wen = 1'b1;
				r.wdata = loadValue(f3, a + immI);
			end
			7'h23: storeValue(f3, a + immS, b);
			7'h13: begin
				r.wen = 1'b1;
				r.wdata = intResult(f3, alt, a, immI);
			end
			7'h33: begin
				r.wen = 1'b1;
				r.wdata = intResult(f3, alt, a, b);
			end
			7'h73: begin
				if (inst == 32'h0010_0073) modelHalted = 1'b1;
			end
			default: ;
		endcase
		if (r.wen && r.rd != 5'd0) modelRegs[r.rd] = r.wdata;
		modelPc = nextPc;
		return r;
	endfunction

	// start pc of each test group in program.hex
	function automatic logic [31:0] groupStart(input int g);
		case (g)
			1: return 32'h058;
			2: return 32'h07c;
			3: return 32'h0bc;
			4: return 32'h0f4;
			5: return 32'h124;
			default: return 32'h000;
		endcase
	endfunction

	function automatic string groupName(input int g);
		case (g)
			1: return "forwarding";
			2: return "loads and stores";
			3: return "branches and loop";
			4: return "jumps and x0";
			5: return "halt";
			default: return "alu";
		endcase
	endfunction

	function automatic int groupOf(input logic [31:0] addr);
		for (int g = NUM_GROUPS - 1; g > 0; g--) begin
			if (addr >= groupStart(g)) return g;
		end
		return 0;
	endfunction

	task automatic reportGroup(input int g);
		$display("test %0d, %s (pc %h): %0d retired, %0d errors", g, groupName(g),
			groupStart(g), groupChecks[g], groupErrs[g]);
	endtask

	task automatic checkRetire(input retireT got, input retireT exp);
		int g;
		g = groupOf(exp.pc);
		if (g != curGroup) begin
			if (curGroup >= 0) reportGroup(curGroup);
			curGroup = g;
		end
		groupChecks[g]++;
		assert (got.pc == exp.pc) else begin
			$display("ERROR at %0t: retired pc %h, expected %h", $time, got.pc, exp.pc);
			groupErrs[g]++;
		end
		assert (got.wen == exp.wen) else begin
			$display("ERROR at %0t: pc %h wen %b, expected %b", $time, exp.pc, got.wen,
				exp.wen);
			groupErrs[g]++;
		end
		if (exp.wen) begin
			assert (got.rd == exp.rd) else begin
				$display("ERROR at %0t: pc %h rd %0d, expected %0d", $time, exp.pc, got.rd,
					exp.rd);
				groupErrs[g]++;
			end
			// a write to x0 has no architectural value to compare
			if (exp.rd != 5'd0) begin
				assert (got.wdata == exp.wdata) else begin
					$display("ERROR at %0t: pc %h wdata %h, expected %h", $time, exp.pc,
						got.wdata, exp.wdata);
					groupErrs[g]++;
				end
			end
		end
	endtask

	task automatic initModel();
		seed = 32'he4e3_0617;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = $random(seed);
		end
		modelRegs[0] = '0;
		for (int i = 0; i < RAM_DEPTH; i++) begin
			modelMem[i] = 8'($random(seed));
		end
		for (int i = 0; i < ROM_DEPTH; i++) begin
			modelRom[i] = NOP_INST;
		end
		$readmemh("program.hex", modelRom);
		modelPc = PC_RESET;
		modelHalted = 1'b0;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			groupChecks[g] = 0;
			groupErrs[g] = 0;
		end
	endtask

	initial begin
		rst = 1'b1;
		cycles = 0;
		retired = 0;
		modelSteps = 0;
		otherErrs = 0;
		curGroup = -1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// compare every retirement against the next model step
	always @(negedge clk) begin
		if (!rst && retire.valid) begin
			retired++;
			if (modelHalted) begin
				$display("instruction at pc %h retired after the program had halted",
					retire.pc);
				otherErrs++;
			end else begin
				want = stepModel();
				modelSteps++;
				checkRetire(retire, want);
			end
		end
	end

	initial begin
		int errs;
		logic [XLEN-1:0] haltPc;
		initModel();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (pc == PC_RESET && !halted && !retire.valid) else begin
			$display("wrong state after reset: pc %h, halted %b, retire valid %b", pc,
				halted, retire.valid);
			otherErrs++;
		end
		wait (halted === 1'b1);
		haltPc = pc;
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			assert (halted === 1'b1) else begin
				$display("halted dropped after the core had stopped");
				otherErrs++;
			end
			assert (pc == haltPc) else begin
				$display("pc moved to %h after the core had halted at %h", pc, haltPc);
				otherErrs++;
			end
		end
		if (curGroup >= 0) reportGroup(curGroup);
		assert (modelHalted) else begin
			$display("the core halted before the model reached EBREAK");
			otherErrs++;
		end
		assert (retired == modelSteps) else begin
			$display("the core retired %0d instructions, the model %0d", retired, modelSteps);
			otherErrs++;
		end
		errs = otherErrs;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			errs += groupErrs[g];
		end
		$display("%0d tests, %0d retired, %0d in the model, %0d errors", NUM_GROUPS,
			retired, modelSteps, errs);
		if (errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu import cpuPkg::*; (
	input logic clk,
	input logic rst,
	output logic [XLEN-1:0] pc,
	output retireT retire,
	output logic halted
);

	logic [XLEN-1:0] fetchInst;
	logic [XLEN-1:0] ifIdInst;
	stageT ifId;
	stageT ifIdNext;
	ctrlT idCtrl;
	logic [REG_ID_W-1:0] idRd;
	logic [REG_ID_W-1:0] idRs1;
	logic [REG_ID_W-1:0] idRs2;
	logic [XLEN-1:0] idImm;
	logic [XLEN-1:0] rfData1;
	logic [XLEN-1:0] rfData2;
	logic [XLEN-1:0] fwdA;
	logic [XLEN-1:0] fwdB;
	stageT idEx;
	stageT idExNext;
	logic [XLEN-1:0] exOpA;
	logic [XLEN-1:0] exOpB;
	logic [XLEN-1:0] aluA;
	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] target;
	logic aluTaken;
	logic redirect;
	logic exHalt;
	logic kill;
	logic haltSeen;
	stageT exOut;
	stageT exMem;
	ctrlT memCtrl;
	logic [XLEN-1:0] memLoadData;
	stageT memWbNext;
	stageT memWb;

	// load in MEM whose data the ID-stage selection could not see yet
	function automatic logic loadHit(input stageT m, input logic [REG_ID_W-1:0] src);
		return m.valid && m.ctrl.memRen && m.ctrl.regWen && m.rd != '0 && m.rd == src;
	endfunction

	// IF
	instRom uInstRom (
		.addr(pc),
		.inst(fetchInst)
	);

	always_comb begin
		ifIdNext = '0;
		ifIdNext.valid = !(kill || haltSeen);
		ifIdNext.pc = pc;
	end

	// ID
	decoder uDecoder (
		.inst(ifIdInst),
		.ctrl(idCtrl),
		.rd(idRd),
		.rs1(idRs1),
		.rs2(idRs2),
		.imm(idImm)
	);

	regFile uRegFile (
		.clk(clk),
		.rs1(idRs1),
		.rs2(idRs2),
		.rd(memWb.rd),
		.wen(memWb.valid && memWb.ctrl.regWen),
		.wdata(memWb.result),
		.rdata1(rfData1),
		.rdata2(rfData2)
	);

	forwardUnit uForwardUnit (
		.rs1(idRs1),
		.rs2(idRs2),
		.rfData1(rfData1),
		.rfData2(rfData2),
		.exStage(exOut),
		.memStage(exMem),
		.wbStage(memWb),
		.memLoadData(memLoadData),
		.opA(fwdA),
		.opB(fwdB)
	);

	always_comb begin
		idExNext.valid = ifId.valid && !kill;
		idExNext.pc = ifId.pc;
		idExNext.rd = idRd;
		idExNext.rs1 = idRs1;
		idExNext.rs2 = idRs2;
		idExNext.opA = fwdA;
		idExNext.opB = fwdB;
		idExNext.imm = idImm;
		idExNext.result = '0;
		idExNext.ctrl = idCtrl;
	end

	// EX
	assign exOpA = loadHit(exMem, idEx.rs1) ? memLoadData : idEx.opA;
	assign exOpB = loadHit(exMem, idEx.rs2) ? memLoadData : idEx.opB;
	assign aluA = idEx.ctrl.usePcA ? idEx.pc : exOpA;
	assign aluB = idEx.ctrl.useImm ? idEx.imm : exOpB;

	alu uAlu (
		.a(aluA),
		.b(aluB),
		.op(idEx.ctrl.aluOp),
		.brOp(idEx.ctrl.brOp),
		.result(aluResult),
		.taken(aluTaken)
	);

	// jumps take the adder output, branches add the offset to their own pc
	assign target = (idEx.ctrl.brOp == BR_JAL || idEx.ctrl.brOp == BR_JALR) ?
		{aluResult[XLEN-1:1], 1'b0} : idEx.pc + idEx.imm;
	assign redirect = idEx.valid && aluTaken;
	assign exHalt = idEx.valid && idEx.ctrl.isHalt;
	assign kill = redirect || exHalt;

	always_comb begin
		exOut = idEx;
		exOut.opA = exOpA;
		exOut.opB = exOpB;
		exOut.result = idEx.ctrl.isLink ? idEx.pc + XLEN'(4) : aluResult;
	end

	// MEM
	always_comb begin
		memCtrl = exMem.ctrl;
		memCtrl.memWen = exMem.ctrl.memWen && exMem.valid;
	end

	dataMem uDataMem (
		.clk(clk),
		.rst(rst),
		.addr(exMem.result),
		.wdata(exMem.opB),
		.ctrl(memCtrl),
		.rdata(memLoadData)
	);

	// writeback value, link results were already chosen in EX
	always_comb begin
		memWbNext = exMem;
		memWbNext.result = exMem.ctrl.memRen ? memLoadData : exMem.result;
	end

	always_ff @(posedge clk) begin
		ifId <= ifIdNext;
		ifIdInst <= fetchInst;
		idEx <= idExNext;
		exMem <= exOut;
		memWb <= memWbNext;
		if (rst) begin
			ifId.valid <= 1'b0;
			idEx.valid <= 1'b0;
			exMem.valid <= 1'b0;
			memWb.valid <= 1'b0;
		end
	end

	// pc freezes once an ebreak reaches EX
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= PC_RESET;
			haltSeen <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (redirect) pc <= target;
			else if (!(exHalt || haltSeen)) pc <= pc + XLEN'(4);
			if (exHalt) haltSeen <= 1'b1;
			if (exMem.valid && exMem.ctrl.isHalt) halted <= 1'b1;
		end
	end

	always_comb begin
		retire.valid = memWb.valid;
		retire.pc = memWb.pc;
		retire.rd = memWb.rd;
		retire.wen = memWb.ctrl.regWen;
		retire.wdata = memWb.result;
	end

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic [XLEN-1:0] addr,
	input logic [XLEN-1:0] wdata,
	input ctrlT ctrl,
	output logic [XLEN-1:0] rdata
);

	logic [7:0] ram [RAM_DEPTH];
	logic [RAM_AW-3:0] wordAddr;
	logic [1:0] lane;
	logic [3:0] byteEn;
	logic [XLEN-1:0] laneData;
	logic [XLEN-1:0] rawWord;
	logic [XLEN-1:0] shifted;

	assign wordAddr = addr[RAM_AW-1:2];
	assign lane = addr[1:0];

	// replicate store data on every lane, the enables pick the bytes
	always_comb begin
		case (ctrl.memSize)
			MEM_BYTE: begin
				byteEn = 4'b0001 << lane;
				laneData = {4{wdata[7:0]}};
			end
			MEM_HALF: begin
				byteEn = 4'b0011 << lane;
				laneData = {2{wdata[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				laneData = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RAM_DEPTH; i++) begin
				ram[i] <= 8'h00;
			end
		end else if (ctrl.memWen) begin
			for (int b = 0; b < 4; b++) begin
				if (byteEn[b]) ram[{wordAddr, 2'(b)}] <= laneData[8*b +: 8];
			end
		end
	end

	assign rawWord = {ram[{wordAddr, 2'd3}], ram[{wordAddr, 2'd2}],
		ram[{wordAddr, 2'd1}], ram[{wordAddr, 2'd0}]};
	assign shifted = rawWord >> {lane, 3'b000};

	always_comb begin
		case (ctrl.memSize)
			MEM_BYTE: rdata = ctrl.memUnsigned ? {24'b0, shifted[7:0]} :
				{{24{shifted[7]}}, shifted[7:0]};
			MEM_HALF: rdata = ctrl.memUnsigned ? {16'b0, shifted[15:0]} :
				{{16{shifted[15]}}, shifted[15:0]};
			default: rdata = shifted;
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b,
	input aluOpE op,
	input brOpE brOp,
	output logic [XLEN-1:0] result,
	output logic taken
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		unique case (op)
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << shamt;
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $unsigned($signed(a) >>> shamt);
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_PASSB: result = b;
			default: result = a + b;
		endcase
	end

	// comparator works on the raw register operands
	always_comb begin
		unique case (brOp)
			BR_EQ: taken = (a == b);
			BR_NE: taken = (a != b);
			BR_LT: taken = ($signed(a) < $signed(b));
			BR_GE: taken = ($signed(a) >= $signed(b));
			BR_LTU: taken = (a < b);
			BR_GEU: taken = (a >= b);
			BR_JAL, BR_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

endmodule

//--- forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit import cpuPkg::*; (
	input logic [REG_ID_W-1:0] rs1,
	input logic [REG_ID_W-1:0] rs2,
	input logic [XLEN-1:0] rfData1,
	input logic [XLEN-1:0] rfData2,
	input stageT exStage,
	input stageT memStage,
	input stageT wbStage,
	input logic [XLEN-1:0] memLoadData,
	output logic [XLEN-1:0] opA,
	output logic [XLEN-1:0] opB
);

	logic [XLEN-1:0] memValue;

	// a stage only forwards if it really writes a nonzero register
	function automatic logic hit(input stageT s, input logic [REG_ID_W-1:0] idx);
		return s.valid && s.ctrl.regWen && s.rd != '0 && s.rd == idx;
	endfunction

	assign memValue = memStage.ctrl.memRen ? memLoadData : memStage.result;

	// youngest producer wins
	always_comb begin
		if (hit(exStage, rs1)) opA = exStage.result;
		else if (hit(memStage, rs1)) opA = memValue;
		else if (hit(wbStage, rs1)) opA = wbStage.result;
		else opA = rfData1;

		if (hit(exStage, rs2)) opB = exStage.result;
		else if (hit(memStage, rs2)) opB = memValue;
		else if (hit(wbStage, rs2)) opB = wbStage.result;
		else opB = rfData2;
	end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input logic clk,
	input logic [REG_ID_W-1:0] rs1,
	input logic [REG_ID_W-1:0] rs2,
	input logic [REG_ID_W-1:0] rd,
	input logic wen,
	input logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// same-cycle write goes straight through to the read ports
	always_comb begin
		if (rs1 == '0) rdata1 = '0;
		else if (wen && rd == rs1) rdata1 = wdata;
		else rdata1 = regs[rs1];
		if (rs2 == '0) rdata2 = '0;
		else if (wen && rd == rs2) rdata2 = wdata;
		else rdata2 = regs[rs2];
	end

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
	input logic [XLEN-1:0] inst,
	output ctrlT ctrl,
	output logic [REG_ID_W-1:0] rd,
	output logic [REG_ID_W-1:0] rs1,
	output logic [REG_ID_W-1:0] rs2,
	output logic [XLEN-1:0] imm
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] immI;
	logic [XLEN-1:0] immS;
	logic [XLEN-1:0] immB;
	logic [XLEN-1:0] immU;
	logic [XLEN-1:0] immJ;
	aluOpE intOp;
	logic opOk;
	logic opImmOk;

	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct7 is only free for sub and sra
	assign opOk = (funct7 == 7'b0000000) ||
		(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
	assign opImmOk = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
		(funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) : 1'b1;

	always_comb begin
		unique case (funct3)
			3'b000: intOp = ALU_ADD;
			3'b001: intOp = ALU_SLL;
			3'b010: intOp = ALU_SLT;
			3'b011: intOp = ALU_SLTU;
			3'b100: intOp = ALU_XOR;
			3'b101: intOp = inst[30] ? ALU_SRA : ALU_SRL;
			3'b110: intOp = ALU_OR;
			default: intOp = ALU_AND;
		endcase
	end

	always_comb begin
		// anything not matched below retires as a no-op
		ctrl = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.brOp = BR_NONE;
		ctrl.memSize = MEM_WORD;
		imm = immI;
		case (inst[6:0])
			OPC_LUI: begin
				ctrl.aluOp = ALU_PASSB;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				imm = immU;
			end
			OPC_AUIPC: begin
				ctrl.usePcA = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				imm = immU;
			end
			OPC_JAL: begin
				ctrl.brOp = BR_JAL;
				ctrl.usePcA = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.regWen = 1'b1;
				ctrl.isLink = 1'b1;
				imm = immJ;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					ctrl.brOp = BR_JALR;
					ctrl.useImm = 1'b1;
					ctrl.regWen = 1'b1;
					ctrl.isLink = 1'b1;
				end
			end
			OPC_BRANCH: begin
				imm = immB;
				case (funct3)
					3'b000: ctrl.brOp = BR_EQ;
					3'b001: ctrl.brOp = BR_NE;
					3'b100: ctrl.brOp = BR_LT;
					3'b101: ctrl.brOp = BR_GE;
					3'b110: ctrl.brOp = BR_LTU;
					3'b111: ctrl.brOp = BR_GEU;
					default: ctrl.brOp = BR_NONE;
				endcase
			end
			OPC_LOAD: begin
				if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin
					ctrl.memSize = memSizeE'(funct3[1:0]);
					ctrl.memUnsigned = funct3[2];
					ctrl.memRen = 1'b1;
					ctrl.regWen = 1'b1;
					ctrl.useImm = 1'b1;
				end
			end
			OPC_STORE: begin
				imm = immS;
				if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
					ctrl.memSize = memSizeE'(funct3[1:0]);
					ctrl.memWen = 1'b1;
					ctrl.useImm = 1'b1;
				end
			end
			OPC_OPIMM: begin
				if (opImmOk) begin
					ctrl.aluOp = intOp;
					ctrl.useImm = 1'b1;
					ctrl.regWen = 1'b1;
				end
			end
			OPC_OP: begin
				if (opOk) begin
					ctrl.aluOp = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : intOp;
					ctrl.regWen = 1'b1;
				end
			end
			OPC_SYSTEM: begin
				ctrl.isHalt = (inst == EBREAK_INST);
			end
			default: ;
		endcase
	end

endmodule

//--- instRom.sv
`timescale 1ns/1ps

module instRom import cpuPkg::*; (
	input logic [XLEN-1:0] addr,
	output logic [XLEN-1:0] inst
);

	logic [XLEN-1:0] rom [ROM_DEPTH];
	logic [XLEN-3:0] wordIdx;

	// words past the end of program.hex stay no-ops
	initial begin
		for (int i = 0; i < ROM_DEPTH; i++) begin
			rom[i] = NOP_INST;
		end
		$readmemh("program.hex", rom);
	end

	assign wordIdx = addr[XLEN-1:2];
	assign inst = (wordIdx < ROM_DEPTH) ? rom[wordIdx[ROM_AW-1:0]] : NOP_INST;

endmodule

//--- cpuPkg.sv
package cpuPkg;

	localparam int XLEN = 32;
	localparam int REG_ID_W = 5;
	localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000;
	localparam int ROM_DEPTH = 256;
	localparam int ROM_AW = $clog2(ROM_DEPTH);
	localparam int RAM_DEPTH = 1024;
	localparam int RAM_AW = $clog2(RAM_DEPTH);

	// addi x0, x0, 0 and the halt encoding
	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;
	localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OPIMM  = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
	} aluOpE;

	typedef enum logic [3:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
	} brOpE;

	// encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} memSizeE;

	typedef struct packed {
		aluOpE aluOp;
		brOpE brOp;
		memSizeE memSize;
		logic useImm;
		logic usePcA;
		logic regWen;
		logic memRen;
		logic memWen;
		logic memUnsigned;
		logic isLink;
		logic isHalt;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [REG_ID_W-1:0] rd;
		logic [REG_ID_W-1:0] rs1;
		logic [REG_ID_W-1:0] rs2;
		logic [XLEN-1:0] opA;
		logic [XLEN-1:0] opB;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] result;
		ctrlT ctrl;
	} stageT;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [REG_ID_W-1:0] rd;
		logic wen;
		logic [XLEN-1:0] wdata;
	} retireT;

endpackage
